/* hdl/erx_pkg.sv */
package erx_pkg;

   // Mesh transaction widths
   localparam int ADDR_W   = 32;
   localparam int DATA_W   = 32;
   localparam int PACKET_W = 104;                   // 8 + ADDR_W + DATA_W + ADDR_W

   // Chip identity in upper address bits
   localparam int              ID_W    = 12;
   localparam logic [ID_W-1:0] CHIP_ID = 12'h800;  // Local chip, never remapped

   localparam logic [7:0] FRAME_ON = 8'hff;         // Frame byte of a valid beat

   localparam logic [1:0] REMAP_STATIC = 2'd1;      // Select/pattern remap

   // Receive queues
   localparam int                 FIFO_AW        = 5;
   localparam logic [FIFO_AW:0]   FIFO_DEPTH     = {1'b1, {FIFO_AW{1'b0}}};
   localparam logic [FIFO_AW:0]   FIFO_PROG_FULL = (FIFO_AW+1)'(24);  // Wait threshold

   // One mesh transaction, write bit at the top
   typedef struct packed {
      logic              write;       // 1 write, 0 read
      logic [1:0]        datamode;    // Transfer size
      logic [4:0]        ctrlmode;
      logic [ADDR_W-1:0] dstaddr;
      logic [DATA_W-1:0] data;
      logic [ADDR_W-1:0] srcaddr;     // Return address for reads
   } packet_t;

   // Static receive configuration
   typedef struct packed {
      logic            rx_enable;     // Low drops incoming transactions
      logic [1:0]      remap_mode;    // 0 none, 1 static, others none
      logic [ID_W-1:0] remap_sel;     // Upper address bits to replace
      logic [ID_W-1:0] remap_pattern; // Replacement values
   } cfg_t;

   // Output queue selection
   typedef enum logic [1:0] {
      CH_WR,                          // Write to remote space
      CH_RD,                          // Read request
      CH_RR                           // Write into local chip, read response
   } chan_t;

endpackage

/* hdl/erx_deframer.sv */
`timescale 1ns/10ps

module erx_deframer (
   input  logic             rx_lclk_div4,
   input  logic             rst_n,
   input  logic             rx_enable,        // Discard pairs while low
   input  logic [7:0]       rx_frame_par,     // Frame byte per beat
   input  logic [63:0]      rx_data_par,      // Deserialized beat data
   output logic             valid,            // One cycle per rebuilt packet
   output erx_pkg::packet_t packet
);

   logic                       frame_on;      // Current beat is framed
   logic                       beat_odd;      // Next framed beat is beat 1
   logic                       pair_done;     // Beat 1 arriving now
   logic [7:0]                 cmd_q;         // Command byte from beat 0
   logic [erx_pkg::ADDR_W-1:0] dstaddr_q;     // Destination from beat 0

   assign frame_on  = (rx_frame_par == erx_pkg::FRAME_ON);
   assign pair_done = frame_on & beat_odd;

   // Beat position, alternates on framed beats
   always_ff @(posedge rx_lclk_div4 or negedge rst_n) begin
      if (!rst_n) begin
         beat_odd <= 1'b0;
      end else if (frame_on) begin
         beat_odd <= ~beat_odd;              // Back to back transactions
      end else begin
         beat_odd <= 1'b0;                   // Frame drop realigns to beat 0
      end
   end

   // Hold beat 0 until its partner shows up
   always_ff @(posedge rx_lclk_div4) begin
      if (frame_on && !beat_odd) begin
         cmd_q     <= rx_data_par[63:56];    // write, datamode, ctrlmode
         dstaddr_q <= rx_data_par[31:0];
      end
   end

   // Strobe only for enabled pairs
   always_ff @(posedge rx_lclk_div4 or negedge rst_n) begin
      if (!rst_n) begin
         valid <= 1'b0;
      end else begin
         valid <= pair_done & rx_enable;
      end
   end

   // Packet assembly on beat 1
   always_ff @(posedge rx_lclk_div4) begin
      if (pair_done) begin
         packet.write    <= cmd_q[7];
         packet.datamode <= cmd_q[6:5];
         packet.ctrlmode <= cmd_q[4:0];
         packet.dstaddr  <= dstaddr_q;
         packet.data     <= rx_data_par[63:32];
         packet.srcaddr  <= rx_data_par[31:0];
      end
   end

endmodule

/* hdl/erx_remap.sv */
`timescale 1ns/10ps

module erx_remap (
   input  logic                       rx_lclk_div4,
   input  logic                       rst_n,
   input  logic [1:0]                 cfg_remap_mode,  // Only static mode acts
   input  logic [erx_pkg::ID_W-1:0]   remap_sel,       // Bits to overwrite
   input  logic [erx_pkg::ID_W-1:0]   remap_pattern,   // Values for selected bits
   input  logic                       in_valid,
   input  erx_pkg::packet_t           in_packet,
   output logic                       out_valid,
   output erx_pkg::packet_t           out_packet
);

   localparam int UP_LSB = erx_pkg::ADDR_W - erx_pkg::ID_W;  // Lowest id bit

   logic [erx_pkg::ID_W-1:0] upper_in;      // Incoming id field
   logic [erx_pkg::ID_W-1:0] upper_static;  // Select/pattern merge
   logic                     bypass;        // Already addressed to this chip
   logic                     static_on;
   erx_pkg::packet_t         remapped;

   assign upper_in     = in_packet.dstaddr[erx_pkg::ADDR_W-1:UP_LSB];
   assign bypass       = (upper_in == erx_pkg::CHIP_ID);
   assign static_on    = (cfg_remap_mode == erx_pkg::REMAP_STATIC) & ~bypass;
   assign upper_static = (remap_sel & remap_pattern) | (~remap_sel & upper_in);

   // Only dstaddr upper bits can change
   always_comb begin
      remapped = in_packet;
      if (static_on) begin
         remapped.dstaddr[erx_pkg::ADDR_W-1:UP_LSB] = upper_static;
      end
   end

   always_ff @(posedge rx_lclk_div4 or negedge rst_n) begin
      if (!rst_n) begin
         out_valid <= 1'b0;
      end else begin
         out_valid <= in_valid;              // Fixed one cycle stage
      end
   end

   always_ff @(posedge rx_lclk_div4) begin
      if (in_valid) begin
         out_packet <= remapped;
      end
   end

endmodule

/* hdl/erx_disty.sv */
`timescale 1ns/10ps

module erx_disty (
   input  logic             rx_lclk_div4,
   input  logic             rst_n,
   input  logic             in_valid,
   input  erx_pkg::packet_t in_packet,
   input  logic             wr_fill,          // Write queue prog full
   input  logic             rd_fill,          // Read request queue prog full
   input  logic             rr_fill,          // Read response queue prog full
   output logic             wr_push,
   output logic             rd_push,
   output logic             rr_push,
   output erx_pkg::packet_t push_packet,      // Shared by all three queues
   output logic             rx_wr_wait,       // Back-pressure for writes
   output logic             rx_rd_wait        // Back-pressure for reads
);

   localparam int UP_LSB = erx_pkg::ADDR_W - erx_pkg::ID_W;

   erx_pkg::chan_t chan;                      // Target queue of in_packet
   logic           to_self;                   // Address inside this chip

   assign to_self = (in_packet.dstaddr[erx_pkg::ADDR_W-1:UP_LSB] == erx_pkg::CHIP_ID);

   // Routing decision on the remapped address
   always_comb begin
      if (!in_packet.write) begin
         chan = erx_pkg::CH_RD;              // All reads
      end else if (to_self) begin
         chan = erx_pkg::CH_RR;              // Writes back into local space
      end else begin
         chan = erx_pkg::CH_WR;
      end
   end

   // One strobe per packet, no stall
   always_ff @(posedge rx_lclk_div4 or negedge rst_n) begin
      if (!rst_n) begin
         wr_push <= 1'b0;
         rd_push <= 1'b0;
         rr_push <= 1'b0;
      end else begin
         wr_push <= in_valid & (chan == erx_pkg::CH_WR);
         rd_push <= in_valid & (chan == erx_pkg::CH_RD);
         rr_push <= in_valid & (chan == erx_pkg::CH_RR);
      end
   end

   always_ff @(posedge rx_lclk_div4) begin
      if (in_valid) begin
         push_packet <= in_packet;
      end
   end

   // Writes can land in wr or rr, so both hold off the write side
   assign rx_wr_wait = wr_fill | rr_fill;
   assign rx_rd_wait = rd_fill;

endmodule

/* hdl/erx_fifo.sv */
`timescale 1ns/10ps

module erx_fifo (
   input  logic             rx_lclk_div4,
   input  logic             rst_n,
   input  logic             push,             // Write strobe from distributor
   input  erx_pkg::packet_t din,
   output logic             prog_full,        // At or above wait threshold
   input  logic             consumer_wait,    // Holds the head packet
   output logic             access,           // dout valid this cycle
   output erx_pkg::packet_t dout
);

   localparam int AW = erx_pkg::FIFO_AW;

   logic [erx_pkg::PACKET_W-1:0] mem [0:(1<<AW)-1];  // Packet storage
   logic [AW-1:0]                wr_ptr;
   logic [AW-1:0]                rd_ptr;
   logic [AW:0]                  count;      // Occupancy, 0 to depth
   logic                         full;
   logic                         empty;
   logic                         wr_en;      // Accepted push
   logic                         rd_en;      // Pop into output register

   assign full      = (count == erx_pkg::FIFO_DEPTH);
   assign empty     = (count == '0);
   assign wr_en     = push & ~full;           // Push into full queue is lost
   assign rd_en     = ~empty & ~consumer_wait;
   assign prog_full = (count >= erx_pkg::FIFO_PROG_FULL);

   // Pointers and occupancy
   always_ff @(posedge rx_lclk_div4 or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
         access <= 1'b0;
      end else begin
         access <= rd_en;                     // Output register now loaded
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;          // Wraps at depth
         end
         if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;          // Both or neither
         endcase
      end
   end

   // Storage and registered head
   always_ff @(posedge rx_lclk_div4) begin
      if (wr_en) begin
         mem[wr_ptr] <= din;
      end
      if (rd_en) begin
         dout <= erx_pkg::packet_t'(mem[rd_ptr]);
      end
   end

endmodule

/* hdl/erx_top.sv */
`timescale 1ns/10ps

module erx_top (
   input  logic             rx_lclk_div4,     // Divided link clock, whole design
   input  logic             rst_n,
   input  logic [7:0]       rx_frame_par,     // Link frame byte
   input  logic [63:0]      rx_data_par,      // Link data beat
   input  erx_pkg::cfg_t    cfg,              // Static receive setup
   output logic             rx_wr_wait,       // To link sender
   output logic             rx_rd_wait,
   // Write channel
   output logic             rxwr_access,
   output erx_pkg::packet_t rxwr_packet,
   input  logic             rxwr_wait,
   // Read request channel
   output logic             rxrd_access,
   output erx_pkg::packet_t rxrd_packet,
   input  logic             rxrd_wait,
   // Read response channel
   output logic             rxrr_access,
   output erx_pkg::packet_t rxrr_packet,
   input  logic             rxrr_wait
);

   logic             df_valid;                // Deframer to remap
   erx_pkg::packet_t df_packet;
   logic             rm_valid;                // Remap to distributor
   erx_pkg::packet_t rm_packet;
   logic             wr_push;                 // Distributor to queues
   logic             rd_push;
   logic             rr_push;
   erx_pkg::packet_t push_packet;
   logic             wr_fill;                 // Queue prog full levels
   logic             rd_fill;
   logic             rr_fill;

   erx_deframer erx_deframer (
      .rx_lclk_div4 (rx_lclk_div4),
      .rst_n        (rst_n),
      .rx_enable    (cfg.rx_enable),
      .rx_frame_par (rx_frame_par),
      .rx_data_par  (rx_data_par),
      .valid        (df_valid),
      .packet       (df_packet)
   );

   erx_remap erx_remap (
      .rx_lclk_div4   (rx_lclk_div4),
      .rst_n          (rst_n),
      .cfg_remap_mode (cfg.remap_mode),
      .remap_sel      (cfg.remap_sel),
      .remap_pattern  (cfg.remap_pattern),
      .in_valid       (df_valid),
      .in_packet      (df_packet),
      .out_valid      (rm_valid),
      .out_packet     (rm_packet)
   );

   erx_disty erx_disty (
      .rx_lclk_div4 (rx_lclk_div4),
      .rst_n        (rst_n),
      .in_valid     (rm_valid),
      .in_packet    (rm_packet),
      .wr_fill      (wr_fill),
      .rd_fill      (rd_fill),
      .rr_fill      (rr_fill),
      .wr_push      (wr_push),
      .rd_push      (rd_push),
      .rr_push      (rr_push),
      .push_packet  (push_packet),
      .rx_wr_wait   (rx_wr_wait),
      .rx_rd_wait   (rx_rd_wait)
   );

   // Write queue
   erx_fifo rxwr_fifo (
      .rx_lclk_div4  (rx_lclk_div4),
      .rst_n         (rst_n),
      .push          (wr_push),
      .din           (push_packet),
      .prog_full     (wr_fill),
      .consumer_wait (rxwr_wait),
      .access        (rxwr_access),
      .dout          (rxwr_packet)
   );

   // Read request queue
   erx_fifo rxrd_fifo (
      .rx_lclk_div4  (rx_lclk_div4),
      .rst_n         (rst_n),
      .push          (rd_push),
      .din           (push_packet),
      .prog_full     (rd_fill),
      .consumer_wait (rxrd_wait),
      .access        (rxrd_access),
      .dout          (rxrd_packet)
   );

   // Read response queue
   erx_fifo rxrr_fifo (
      .rx_lclk_div4  (rx_lclk_div4),
      .rst_n         (rst_n),
      .push          (rr_push),
      .din           (push_packet),
      .prog_full     (rr_fill),
      .consumer_wait (rxrr_wait),
      .access        (rxrr_access),
      .dout          (rxrr_packet)
   );

endmodule

/* tb/erx_scoreboard.sv */
`timescale 1ns/10ps

module erx_scoreboard (
   input logic             rx_lclk_div4,
   input logic             rst_n,
   input logic             rx_wr_wait,
   input logic             rx_rd_wait,
   input logic             rxwr_access,
   input erx_pkg::packet_t rxwr_packet,
   input logic             rxrd_access,
   input erx_pkg::packet_t rxrd_packet,
   input logic             rxrr_access,
   input erx_pkg::packet_t rxrr_packet
);

   erx_pkg::packet_t exp_q [0:2][$];                  // One queue per chan_t

   int mismatches = 0;                                // Wrong packet contents
   int strays     = 0;                                // Packet with nothing expected
   int leftovers  = 0;                                // Expected, never delivered
   int pending    = 0;                                // Still in flight

   task automatic expect_packet(input erx_pkg::chan_t chan, input erx_pkg::packet_t pkt);
      exp_q[int'(chan)].push_back(pkt);
      pending++;
   endtask

   // Outstanding packets bound the queue fill from above
   function automatic bit may_reach_level(input int ch);
      return exp_q[ch].size() >= int'(erx_pkg::FIFO_PROG_FULL);
   endfunction

   // Compare against the oldest packet of that channel
   task automatic check_head(input int ch, input string name, input erx_pkg::packet_t got);
      erx_pkg::packet_t want;
      if (exp_q[ch].size() == 0) begin
         strays++;
         $display("Unexpected packet %h on %s, nothing was sent to that channel", got, name);
      end else begin
         want = exp_q[ch].pop_front();
         pending--;
         if (got !== want) begin
            mismatches++;
            $display("Error: %s expected %h actual %h", name, want, got);
         end
      end
   endtask

   task automatic check_leftovers;
      for (int ch = 0; ch < 3; ch++) begin
         if (exp_q[ch].size() != 0) begin
            leftovers += exp_q[ch].size();
            $display("Channel %0d still owes %0d expected packets", ch, exp_q[ch].size());
         end
      end
   endtask

   // Channel outputs are registered, settled over the whole cycle
   always @(posedge rx_lclk_div4) begin
      if (rst_n) begin
         // Link wait only once a queue may be at its threshold
         if (rx_wr_wait && !may_reach_level(int'(erx_pkg::CH_WR))
                        && !may_reach_level(int'(erx_pkg::CH_RR))) begin
            mismatches++;
            $display("Error: rx_wr_wait expected %h actual %h", 1'b0, rx_wr_wait);
         end
         if (rx_rd_wait && !may_reach_level(int'(erx_pkg::CH_RD))) begin
            mismatches++;
            $display("Error: rx_rd_wait expected %h actual %h", 1'b0, rx_rd_wait);
         end
         if (rxwr_access) check_head(int'(erx_pkg::CH_WR), "rxwr_packet", rxwr_packet);
         if (rxrd_access) check_head(int'(erx_pkg::CH_RD), "rxrd_packet", rxrd_packet);
         if (rxrr_access) check_head(int'(erx_pkg::CH_RR), "rxrr_packet", rxrr_packet);
      end
   end

endmodule

/* tb/erx_chk.sv */
`timescale 1ns/10ps

module erx_chk (
   input logic             rx_lclk_div4,
   input logic             rst_n,
   input logic             rxwr_access,
   input logic             rxrd_access,
   input logic             rxrr_access,
   input logic             rxwr_wait,
   input logic             rxrd_wait,
   input logic             rxrr_wait,
   input erx_pkg::packet_t rxwr_packet,
   input erx_pkg::packet_t rxrd_packet,
   input erx_pkg::packet_t rxrr_packet
);

   int fail_count = 0;                                // Failed assertions

   // Queues stay quiet in reset
   assert property (@(posedge rx_lclk_div4)
      !rst_n |-> !(rxwr_access | rxrd_access | rxrr_access))
      else begin
         fail_count++;
         $error("Channel access while reset is asserted");
      end

   // Held consumer gets nothing new on the next cycle
   assert property (@(posedge rx_lclk_div4) disable iff (!rst_n) rxwr_wait |=> !rxwr_access)
      else begin
         fail_count++;
         $error("rxwr_access one cycle after rxwr_wait");
      end
   assert property (@(posedge rx_lclk_div4) disable iff (!rst_n) rxrd_wait |=> !rxrd_access)
      else begin
         fail_count++;
         $error("rxrd_access one cycle after rxrd_wait");
      end
   assert property (@(posedge rx_lclk_div4) disable iff (!rst_n) rxrr_wait |=> !rxrr_access)
      else begin
         fail_count++;
         $error("rxrr_access one cycle after rxrr_wait");
      end

   // Offered packets fully defined
   assert property (@(posedge rx_lclk_div4) rxwr_access |-> !$isunknown(rxwr_packet))
      else begin
         fail_count++;
         $error("rxwr_packet unknown while rxwr_access is high");
      end
   assert property (@(posedge rx_lclk_div4) rxrd_access |-> !$isunknown(rxrd_packet))
      else begin
         fail_count++;
         $error("rxrd_packet unknown while rxrd_access is high");
      end
   assert property (@(posedge rx_lclk_div4) rxrr_access |-> !$isunknown(rxrr_packet))
      else begin
         fail_count++;
         $error("rxrr_packet unknown while rxrr_access is high");
      end

endmodule

bind erx_top erx_chk i_erx_chk (.*);

/* tb/tb_erx.sv */
`timescale 1ns/10ps

module tb_erx;

   localparam int N_LINES    = 14;                    // Rows in the pattern file
   localparam int N_COLS     = 8;                     // Words per row
   localparam int RST_CYCLES = 16;

   logic             rx_lclk_div4;
   logic             rst_n;
   logic [7:0]       rx_frame_par;
   logic [63:0]      rx_data_par;
   erx_pkg::cfg_t    cfg;
   logic             rx_wr_wait, rx_rd_wait;          // Link back-pressure
   logic             rxwr_access, rxrd_access, rxrr_access;
   erx_pkg::packet_t rxwr_packet, rxrd_packet, rxrr_packet;
   logic             rxwr_wait, rxrd_wait, rxrr_wait; // Consumer stalls

   logic [31:0] pat [0:N_LINES*N_COLS-1];             // Raw pattern words
   integer      seed = 32'hf79;
   int          wdog_cycles;
   int          tb_errors = 0;
   logic        hold = 1'b0;                          // Consumer waits forced high
   logic        group_hold = 1'b0;                    // Current group is a hold group
   logic        saw_wait;                             // Link wait rose under hold

   erx_top i_erx_top (.*);

   erx_scoreboard i_sb (.*);

   initial rx_lclk_div4 = 1'b0;
   always #4 rx_lclk_div4 = ~rx_lclk_div4;           // 8 ns period

   // Random stalls, about one cycle in four
   always @(posedge rx_lclk_div4) begin
      #1;
      rxwr_wait = hold | (($random(seed) & 3) == 0);
      rxrd_wait = hold | (($random(seed) & 3) == 0);
      rxrr_wait = hold | (($random(seed) & 3) == 0);
   end

   // Release the hold once the queues push back on the link
   always @(posedge rx_lclk_div4) begin
      if (hold && (rx_wr_wait || rx_rd_wait)) begin
         hold     <= 1'b0;
         saw_wait <= 1'b1;
      end
   end

   // Budget of 200 cycles per packet plus reset
   initial begin
      #1;
      repeat (wdog_cycles) @(posedge rx_lclk_div4);
      $display("Watchdog ran out after %0d cycles, the DUT stopped delivering", wdog_cycles);
      $display("TESTS FAILED");
      $finish;
   end

   // Two framed beats, held off while the matching link wait is up
   task automatic send_packet(input erx_pkg::packet_t pkt);
      while (pkt.write ? rx_wr_wait : rx_rd_wait) begin
         rx_frame_par = 8'h00;                        // Idle, beat position resets
         @(posedge rx_lclk_div4);
         #1;
      end
      rx_frame_par = erx_pkg::FRAME_ON;
      rx_data_par  = {pkt.write, pkt.datamode, pkt.ctrlmode, 24'h0, pkt.dstaddr};
      @(posedge rx_lclk_div4);
      #1;
      rx_data_par = {pkt.data, pkt.srcaddr};          // Beat 1
      @(posedge rx_lclk_div4);
      #1;
   endtask

   // Idle the link until the expected packets are out, bounded
   task automatic drain;
      rx_frame_par = 8'h00;
      for (int n = 0; n < 400 && i_sb.pending != 0; n++) begin
         @(posedge rx_lclk_div4);
      end
      repeat (4) @(posedge rx_lclk_div4);
      #1;
      if (group_hold && !saw_wait) begin
         tb_errors++;
         $display("Link wait did not rise while the consumer waits were held high");
      end
      hold = 1'b0;
   endtask

   initial begin
      erx_pkg::packet_t link_pkt;
      erx_pkg::packet_t want_pkt;
      int               base;
      int               total;
      rst_n        = 1'b1;
      rx_frame_par = 8'h00;
      rx_data_par  = '0;
      cfg          = '0;
      rxwr_wait    = 1'b0;
      rxrd_wait    = 1'b0;
      rxrr_wait    = 1'b0;
      $readmemh("tb/erx_patterns.txt", pat);
      total = 0;
      for (int i = 0; i < N_LINES; i++) begin
         total += pat[i*N_COLS+5];                    // Repeat counts
      end
      wdog_cycles = total * 200 + RST_CYCLES;
      #1;
      rst_n = 1'b0;
      repeat (RST_CYCLES) @(posedge rx_lclk_div4);
      #1;
      rst_n = 1'b1;
      for (int i = 0; i < N_LINES; i++) begin
         base = i * N_COLS;
         if (pat[base][31]) begin                     // New group, reconfigure when idle
            drain();
            cfg        = erx_pkg::cfg_t'(pat[base][26:0]);
            group_hold = pat[base][30];
            hold       = pat[base][30];
            saw_wait   = 1'b0;
         end
         for (int k = 0; k < pat[base+5]; k++) begin
            link_pkt = {pat[base+1][7:0], pat[base+2], 32'(pat[base+3] + k), pat[base+4]};
            want_pkt = link_pkt;
            want_pkt.dstaddr = pat[base+7];
            if (pat[base+6][1:0] != 2'd3) begin       // 3 marks a dropped packet
               i_sb.expect_packet(erx_pkg::chan_t'(pat[base+6][1:0]), want_pkt);
            end
            send_packet(link_pkt);
         end
      end
      drain();
      i_sb.check_leftovers();
      $display("Summary: %0d mismatched, %0d stray, %0d missing, %0d assertion, %0d other",
               i_sb.mismatches, i_sb.strays, i_sb.leftovers,
               i_erx_top.i_erx_chk.fail_count, tb_errors);
      if (i_sb.mismatches + i_sb.strays + i_sb.leftovers
          + i_erx_top.i_erx_chk.fail_count + tb_errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

/* tb/erx_patterns.txt */
// group(31) hold(30) cfg(26:0) | cmd | dstaddr | data | srcaddr | repeat | chan | exp dstaddr
// chan 0 wr, 1 rd, 2 rr, 3 dropped; data counts up by one per repeat
84000000 000000c0 12340010 a5a50001 00000000 00000001 00000000 12340010
00000000 000000c0 12340014 a5a50002 00000000 00000003 00000000 12340014
00000000 00000040 45600020 00000000 80000100 00000002 00000001 45600020
00000000 00000083 80000040 deadbeef 00000000 00000001 00000002 80000040
00000000 00000040 80000044 00000000 81000200 00000001 00000001 80000044
85f00300 000000c0 12340080 11110000 00000000 00000002 00000000 32340080
00000000 000000c0 80000084 22220000 00000000 00000001 00000002 80000084
00000000 00000040 abc00090 00000000 80000300 00000001 00000001 3bc00090
85f00800 000000c0 000000a0 33330000 00000000 00000001 00000002 800000a0
00000000 000000c0 7ff000a4 44440000 00000000 00000001 00000000 8ff000a4
80000000 000000c0 12340100 55550000 00000000 00000004 00000003 12340100
00000000 00000040 45600104 00000000 80000400 00000001 00000003 45600104
c4000000 000000c0 12340200 66660000 00000000 0000001c 00000000 12340200
00000000 00000040 45600204 00000000 80000500 00000002 00000001 45600204

/* filelist.f */
hdl/erx_pkg.sv
hdl/erx_deframer.sv
hdl/erx_remap.sv
hdl/erx_disty.sv
hdl/erx_fifo.sv
hdl/erx_top.sv
tb/erx_scoreboard.sv
tb/erx_chk.sv
tb/tb_erx.sv

/* Bender.yml */
package:
  name: erx

sources:
  - hdl/erx_pkg.sv
  - hdl/erx_deframer.sv
  - hdl/erx_remap.sv
  - hdl/erx_disty.sv
  - hdl/erx_fifo.sv
  - hdl/erx_top.sv
  - target: test
    files:
      - tb/erx_scoreboard.sv
      - tb/erx_chk.sv
      - tb/tb_erx.sv
